// File: hdl/uart_alu_config.svh
`ifndef UART_ALU_CONFIG_SVH
`define UART_ALU_CONFIG_SVH

// serial frame format
`define UART_DATA_BITS      8
`define UART_TICKS_PER_BIT  16
`define UART_TICK_DIVISOR   4       // clocks per oversampling tick, 64 clocks per bit

// alu operation codes
`define OP_ADD  8'h20
`define OP_SUB  8'h22
`define OP_AND  8'h24
`define OP_OR   8'h25
`define OP_XOR  8'h26
`define OP_NOR  8'h27
`define OP_SRA  8'h03
`define OP_SRL  8'h02

`endif

// File: hdl/uart_alu_pkg.sv
`include "uart_alu_config.svh"

package uart_alu_pkg;

    typedef logic [`UART_DATA_BITS-1:0] byte_t;    // payload byte, operand or result
    typedef logic [7:0] opcode_t;
    typedef logic [3:0] tick_count_t;               // ticks within one bit
    typedef logic [2:0] bit_index_t;                // data bit position

    // one-hot transmitter states
    typedef enum logic [3:0] {
        tx_s_idle  = 4'b0001,
        tx_s_start = 4'b0010,
        tx_s_data  = 4'b0100,
        tx_s_stop  = 4'b1000
    } tx_state_t;

    typedef enum logic [1:0] {rx_s_idle, rx_s_start, rx_s_data, rx_s_stop} rx_state_t;

    typedef enum logic [1:0] {seq_wait_a, seq_wait_b, seq_wait_op, seq_send} seq_state_t;

endpackage

// File: hdl/alu_if.sv
`timescale 1ns/100ps

interface alu_if import uart_alu_pkg::*; ();

    byte_t   operand_a;
    byte_t   operand_b;
    opcode_t opcode;
    byte_t   result;

    // sequencer presents the operation, alu answers
    modport sequencer (
        output operand_a, operand_b, opcode,
        input  result
    );

    modport alu (
        input  operand_a, operand_b, opcode,
        output result
    );

endinterface

// File: hdl/baud_tick_gen.sv
`timescale 1ns/100ps
`include "uart_alu_config.svh"

module baud_tick_gen (
    input  logic clock,
    input  logic reset,
    output logic tick
);

    localparam int cnt_w = $clog2(`UART_TICK_DIVISOR);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`UART_TICK_DIVISOR - 1);

    logic [cnt_w-1:0] count;

    // free running divider, one tick per wrap
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == cnt_last) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/100ps
`include "uart_alu_config.svh"

module uart_rx
    import uart_alu_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  rx,
    input  logic  tick,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam tick_count_t mid_tick  = tick_count_t'(`UART_TICKS_PER_BIT / 2 - 1);
    localparam tick_count_t last_tick = tick_count_t'(`UART_TICKS_PER_BIT - 1);
    localparam bit_index_t  last_bit  = bit_index_t'(`UART_DATA_BITS - 1);

    logic        rx_meta, rx_sync, rx_prev;
    rx_state_t   state, state_next;
    tick_count_t tick_cnt, tick_cnt_next;
    bit_index_t  bit_cnt, bit_cnt_next;
    byte_t       shift_reg, shift_next;
    logic        valid_next;

    // two-flop synchronizer plus one stage for edge detect, line idles high
    always_ff @(posedge clock) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= rx_s_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            rx_valid <= valid_next;
        end
    end

    always_ff @(posedge clock) begin
        shift_reg <= shift_next;
    end

    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        shift_next    = shift_reg;
        valid_next    = 1'b0;

        case (state)
            rx_s_idle: begin
                if (rx_prev && !rx_sync) begin     // falling edge, start bit begins
                    tick_cnt_next = '0;
                    state_next    = rx_s_start;
                end
            end
            rx_s_start: begin
                if (tick) begin
                    if (tick_cnt == mid_tick) begin
                        tick_cnt_next = '0;
                        bit_cnt_next  = '0;
                        // glitch if the line is already back high
                        state_next    = rx_sync ? rx_s_idle : rx_s_data;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            rx_s_data: begin
                if (tick) begin
                    if (tick_cnt == last_tick) begin
                        tick_cnt_next = '0;
                        shift_next    = {rx_sync, shift_reg[`UART_DATA_BITS-1:1]};  // lsb first
                        bit_cnt_next  = bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) state_next = rx_s_stop;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            rx_s_stop: begin
                if (tick) begin
                    if (tick_cnt == last_tick) begin
                        valid_next = rx_sync;       // bad stop bit drops the byte
                        state_next = rx_s_idle;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: state_next = rx_s_idle;
        endcase
    end

    assign rx_data = shift_reg;

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/100ps
`include "uart_alu_config.svh"

module uart_tx
    import uart_alu_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  tick,
    input  logic  tx_start,
    input  byte_t tx_data,
    output logic  tx,
    output logic  tx_ready
);

    localparam tick_count_t last_tick = tick_count_t'(`UART_TICKS_PER_BIT - 1);
    localparam bit_index_t  last_bit  = bit_index_t'(`UART_DATA_BITS - 1);

    tx_state_t   state, state_next;
    tick_count_t tick_cnt, tick_cnt_next;
    bit_index_t  bit_cnt, bit_cnt_next;
    byte_t       data_reg, data_next;
    logic        tx_next;

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= tx_s_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            state    <= state_next;
            tick_cnt <= tick_cnt_next;
            bit_cnt  <= bit_cnt_next;
            tx       <= tx_next;
        end
    end

    always_ff @(posedge clock) begin
        data_reg <= data_next;
    end

    // tx_next follows each state change so the line and the state move together
    always_comb begin
        state_next    = state;
        tick_cnt_next = tick_cnt;
        bit_cnt_next  = bit_cnt;
        data_next     = data_reg;
        tx_next       = tx;

        case (state)
            tx_s_idle: begin
                tx_next = 1'b1;
                if (tx_start) begin
                    data_next     = tx_data;        // latch the result byte
                    tick_cnt_next = '0;
                    tx_next       = 1'b0;           // start bit
                    state_next    = tx_s_start;
                end
            end
            tx_s_start: begin
                if (tick) begin
                    if (tick_cnt == last_tick) begin
                        tick_cnt_next = '0;
                        bit_cnt_next  = '0;
                        tx_next       = data_reg[0];
                        state_next    = tx_s_data;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            tx_s_data: begin
                if (tick) begin
                    if (tick_cnt == last_tick) begin
                        tick_cnt_next = '0;
                        bit_cnt_next  = bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) begin
                            tx_next    = 1'b1;      // stop bit
                            state_next = tx_s_stop;
                        end else begin
                            tx_next = data_reg[bit_cnt_next];
                        end
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            tx_s_stop: begin
                if (tick) begin
                    if (tick_cnt == last_tick) state_next = tx_s_idle;
                    else tick_cnt_next = tick_cnt + 1'b1;
                end
            end
            default: begin
                tx_next    = 1'b1;
                state_next = tx_s_idle;
            end
        endcase
    end

    assign tx_ready = (state == tx_s_idle);

endmodule

// File: hdl/alu.sv
`timescale 1ns/100ps
`include "uart_alu_config.svh"

module alu
    import uart_alu_pkg::*;
(
    alu_if.alu bus
);

    bit_index_t shamt;

    assign shamt = bus.operand_b[2:0];     // shifts use b's low bits only

    always_comb begin
        case (bus.opcode)
            `OP_ADD: bus.result = bus.operand_a + bus.operand_b;   // wraps mod 256
            `OP_SUB: bus.result = bus.operand_a - bus.operand_b;
            `OP_AND: bus.result = bus.operand_a & bus.operand_b;
            `OP_OR:  bus.result = bus.operand_a | bus.operand_b;
            `OP_XOR: bus.result = bus.operand_a ^ bus.operand_b;
            `OP_NOR: bus.result = ~(bus.operand_a | bus.operand_b);
            `OP_SRA: bus.result = $signed(bus.operand_a) >>> shamt;
            `OP_SRL: bus.result = bus.operand_a >> shamt;
            default: bus.result = '0;             // unknown opcode answers zero
        endcase
    end

endmodule

// File: hdl/alu_sequencer.sv
`timescale 1ns/100ps

module alu_sequencer
    import uart_alu_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  byte_t        rx_data,
    input  logic         rx_valid,
    input  logic         tx_ready,
    output logic         tx_start,
    output byte_t        tx_data,
    alu_if.sequencer     bus
);

    seq_state_t state;

    // byte order on the line is a, b, opcode
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= seq_wait_a;
        end else begin
            case (state)
                seq_wait_a: begin
                    if (rx_valid) state <= seq_wait_b;
                end
                seq_wait_b: begin
                    if (rx_valid) state <= seq_wait_op;
                end
                seq_wait_op: begin
                    if (rx_valid) state <= seq_send;
                end
                seq_send: begin
                    // bytes arriving here are ignored
                    if (tx_ready) state <= seq_wait_a;
                end
                default: state <= seq_wait_a;
            endcase
        end
    end

    // operand capture
    always_ff @(posedge clock) begin
        if (rx_valid) begin
            case (state)
                seq_wait_a:  bus.operand_a <= rx_data;
                seq_wait_b:  bus.operand_b <= rx_data;
                seq_wait_op: bus.opcode    <= rx_data;
                default: ;
            endcase
        end
    end

    // result is settled by the time send is reached
    assign tx_start = (state == seq_send) && tx_ready;
    assign tx_data  = bus.result;

endmodule

// File: hdl/uart_alu_top.sv
`timescale 1ns/100ps

module uart_alu_top
    import uart_alu_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic rx,
    output logic tx
);

    logic  tick;        // shared by both directions
    byte_t rx_data;
    logic  rx_valid;
    byte_t tx_data;
    logic  tx_start;
    logic  tx_ready;

    alu_if alu_bus ();

    baud_tick_gen u_tick_gen (
        .clock (clock),
        .reset (reset),
        .tick  (tick)
    );

    uart_rx u_rx (
        .clock    (clock),
        .reset    (reset),
        .rx       (rx),
        .tick     (tick),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    alu_sequencer u_seq (
        .clock    (clock),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_ready (tx_ready),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .bus      (alu_bus.sequencer)
    );

    alu u_alu (
        .bus (alu_bus.alu)
    );

    uart_tx u_tx (
        .clock    (clock),
        .reset    (reset),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_ready (tx_ready)
    );

endmodule

// File: verification/uart_alu_asserts.sv
`timescale 1ns/100ps

module uart_alu_asserts
    import uart_alu_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      tx,
    input logic      tx_start,
    input logic      tx_ready,
    input logic      rx_valid,
    input tx_state_t tx_state
);

    // transmitter leaves idle on the clock after a start
    start_accepted: assert property (@(posedge clock) disable iff (reset)
        tx_start |=> ($fell(tx_ready) && !tx))
        else $error("transmitter did not leave idle after tx_start");

    rx_valid_one_cycle: assert property (@(posedge clock) disable iff (reset)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held for more than one cycle");

    idle_line_high: assert property (@(posedge clock) disable iff (reset)
        (tx_state == tx_s_idle) |-> tx)
        else $error("tx low while the transmitter is idle");

endmodule

bind uart_alu_top uart_alu_asserts u_asserts (
    .clock    (clock),
    .reset    (reset),
    .tx       (tx),
    .tx_start (tx_start),
    .tx_ready (tx_ready),
    .rx_valid (rx_valid),
    .tx_state (u_tx.state)
);

// File: verification/uart_alu_tb.sv
`timescale 1ns/100ps
`include "uart_alu_config.svh"

module uart_alu_tb import uart_alu_pkg::*; ();

    localparam int bit_clocks    = 64;
    localparam int start_timeout = 4 * 10 * bit_clocks;   // four frames

    logic clock;
    logic reset;
    logic rx;
    logic tx;

    logic [31:0] rng_state = 32'h5832;
    int          check_count = 0;
    int          error_count = 0;
    byte_t       expected_q[$];         // answers still in flight
    opcode_t     valid_ops [8] = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR,
                                   `OP_XOR, `OP_NOR, `OP_SRA, `OP_SRL};

    uart_alu_top uut (
        .clock (clock),
        .reset (reset),
        .rx    (rx),
        .tx    (tx)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // expected alu answer, from the operation rules
    function automatic byte_t alu_model(input byte_t a, input byte_t b, input opcode_t op);
        logic [15:0] ext;
        ext = {{8{a[7]}}, a} >> b[2:0];      // sign bits shift in from above
        case (op)
            `OP_ADD: return a + b;
            `OP_SUB: return a + ~b + 8'd1;
            `OP_AND: return a & b;
            `OP_OR:  return a | b;
            `OP_XOR: return a ^ b;
            `OP_NOR: return ~(a | b);
            `OP_SRA: return ext[7:0];
            `OP_SRL: return a >> b[2:0];
            default: return 8'h00;
        endcase
    endfunction

    // valid codes all have bit 7 clear
    function automatic opcode_t invalid_opcode(input opcode_t code);
        if (code inside {`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_NOR, `OP_SRA, `OP_SRL})
            return code ^ 8'h80;
        return code;
    endfunction

    function automatic opcode_t random_opcode(input logic [31:0] r);
        if (r[23:20] == 4'h0) return invalid_opcode(r[31:24]);   // roughly one in sixteen
        return valid_ops[r[18:16]];
    endfunction

    task automatic check_value(input string name, input byte_t expected, input byte_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %02h, got %02h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock);
        #2;
    endtask

    // one frame on rx, lsb first
    task automatic send_byte(input byte_t data, input logic stop_bit);
        byte_t shift;
        shift = data;
        rx = 1'b0;
        wait_clocks(bit_clocks);
        repeat (8) begin
            rx = shift[0];
            shift = shift >> 1;
            wait_clocks(bit_clocks);
        end
        rx = stop_bit;
        wait_clocks(bit_clocks);
        rx = 1'b1;
    endtask

    // sampled on the falling clock edge, mid bit
    task automatic receive_byte(output byte_t data, output logic stop, output logic ok);
        int waited;
        waited = 0;
        data = '0;
        stop = 1'b0;
        ok = 1'b0;
        @(negedge clock);
        while (tx !== 1'b0 && waited < start_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (tx !== 1'b0) begin
            $display("timeout: no start bit on tx within %0d clocks", start_timeout);
            error_count++;
            return;
        end
        repeat (bit_clocks / 2 - 1) @(negedge clock);
        if (tx !== 1'b0) begin
            $display("start bit on tx ended early at %0t ns", $time);
            error_count++;
            return;
        end
        repeat (8) begin
            repeat (bit_clocks) @(negedge clock);
            data = {tx, data[7:1]};
        end
        repeat (bit_clocks) @(negedge clock);
        stop = tx;
        ok = 1'b1;
    endtask

    task automatic send_stream(input int count);
        logic [31:0] r;
        opcode_t     op;
        for (int i = 0; i < count; i++) begin
            r = next_random();
            op = random_opcode(r);
            expected_q.push_back(alu_model(r[7:0], r[15:8], op));
            send_byte(r[7:0], 1'b1);
            send_byte(r[15:8], 1'b1);
            send_byte(op, 1'b1);
        end
    endtask

    task automatic collect_answers(input int count);
        byte_t answer;
        logic  stop;
        logic  ok;
        for (int i = 0; i < count; i++) begin
            receive_byte(answer, stop, ok);
            if (!ok) return;
            if (expected_q.size() == 0) begin
                $display("answer byte on tx with no transaction outstanding");
                error_count++;
            end else begin
                check_value("tx byte", expected_q.pop_front(), answer);
                check_value("tx stop bit", 8'h01, {7'd0, stop});
            end
        end
    endtask

    task automatic run_transaction(input byte_t a, input byte_t b, input opcode_t op,
                                   input byte_t expected);
        expected_q.push_back(expected);
        fork
            begin
                send_byte(a, 1'b1);
                send_byte(b, 1'b1);
                send_byte(op, 1'b1);
            end
            collect_answers(1);
        join
        wait_clocks(1);             // back to posedge plus drive delay
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    initial begin
        logic [31:0] r;
        int          errs;
        reset = 1'b1;
        rx = 1'b1;
        wait_clocks(4);
        reset = 1'b0;

        errs = error_count;
        repeat (200) begin
            @(negedge clock);
            check_value("tx", 8'h01, {7'd0, tx});
        end
        wait_clocks(1);
        report_test("idle after reset", errs);

        errs = error_count;
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            run_transaction(r[7:0], r[15:8], valid_ops[r[18:16]],
                            alu_model(r[7:0], r[15:8], valid_ops[r[18:16]]));
        end
        report_test("random operations", errs);

        errs = error_count;
        run_transaction(8'hFF, 8'h01, `OP_ADD, 8'h00);
        run_transaction(8'h00, 8'h01, `OP_SUB, 8'hFF);
        run_transaction(8'h80, 8'h07, `OP_SRA, 8'hFF);
        run_transaction(8'h80, 8'h07, `OP_SRL, 8'h01);
        report_test("edge operands", errs);

        errs = error_count;
        repeat (4) begin
            r = next_random();
            run_transaction(r[7:0], r[15:8], invalid_opcode(r[31:24]), 8'h00);
        end
        report_test("invalid opcode", errs);

        errs = error_count;
        r = next_random();
        send_byte(r[31:24], 1'b0);          // bad stop bit, must be dropped
        wait_clocks(2 * bit_clocks);
        run_transaction(r[7:0], r[15:8], `OP_XOR, alu_model(r[7:0], r[15:8], `OP_XOR));
        report_test("framing error", errs);

        errs = error_count;
        fork
            send_stream(8);
            collect_answers(8);
        join
        wait_clocks(1);
        report_test("back-to-back traffic", errs);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/uart_alu_pkg.sv
hdl/alu_if.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/alu.sv
hdl/alu_sequencer.sv
hdl/uart_alu_top.sv
verification/uart_alu_asserts.sv
verification/uart_alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the uart alu testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 -f project.f \
    --top-module uart_alu_tb --Mdir "$build_dir" -o uart_alu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/uart_alu_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASSED" "$log_file"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $log_file"
exit 1
